//--- vlog.f
+incdir+.
xlate_pkg.sv
pipe_reg.sv
tlb_array.sv
xlate_resolve_stage.sv
xlate_top.sv
tb_clock.sv
xlate_props.sv
xlate_tb.sv

//--- run.sh
#!/bin/sh
# build and run the xlate testbench with Verilator
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --timescale 1ns/1ns --top-module xlate_tb \
    -f vlog.f -o xlate_sim &&
./obj_dir/xlate_sim | tee /dev/stderr | grep -q "TESTBENCH PASSED" &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }

//--- xlate_tb.sv
`timescale 1ns/1ns
`default_nettype none

`include "xlate_settings.svh"

module xlate_tb;
    import xlate_pkg::*;

    localparam int NUM_ENTRIES     = `XLATE_TLB_ENTRIES;
    localparam int NUM_LOOKUPS     = 24;
    localparam int FIRST_LATE      = 20;
    localparam int REWRITE_IDX     = 3;
    localparam int SEED            = 65;
    localparam int WATCHDOG_CYCLES = 20 * (NUM_ENTRIES + NUM_LOOKUPS) + 100;

    typedef struct packed {
        vpn2_t vpn2;
        asid_t asid;
        logic  g;
        pfn_t  pfn0;
        logic  v0;
        logic  d0;
        pfn_t  pfn1;
        logic  v1;
        logic  d1;
    } entry_row_t;

    typedef struct packed {
        vaddr_t    vaddr;
        asid_t     asid;
        logic      store;
        vaddr_t    paddr;
        xlate_ex_e ex;
    } lookup_row_t;

    typedef struct packed {
        int   row;
        int   accept_edge;
        logic check_lat;
    } expect_t;

    logic      aclk;
    logic      rst_n;
    logic      req_valid;
    vaddr_t    req_vaddr;
    asid_t     req_asid;
    logic      req_store;
    logic      req_allowin;
    logic      rsp_valid;
    vaddr_t    rsp_paddr;
    xlate_ex_e rsp_ex;
    logic      rsp_allowin;
    logic      tlb_we;
    tlb_idx_t  w_index;
    vpn2_t     w_vpn2;
    asid_t     w_asid;
    logic      w_g;
    pfn_t      w_pfn0;
    logic      w_v0;
    logic      w_d0;
    pfn_t      w_pfn1;
    logic      w_v1;
    logic      w_d1;

    entry_row_t  entries [NUM_ENTRIES];
    entry_row_t  rewrite_row;
    lookup_row_t lookups [NUM_LOOKUPS];
    expect_t     exp_q [$];
    int          issued;
    int          received = 0;
    int          edge_cnt = 0;
    logic        bp_on;

    tb_clock clk_gen (
        .aclk  (aclk ),
        .rst_n (rst_n)
    );

    xlate_top DUT (.*);

    bind xlate_top xlate_props props (
        .aclk        (aclk       ),
        .rst_n       (rst_n      ),
        .req_allowin (req_allowin),
        .rsp_valid   (rsp_valid  ),
        .rsp_allowin (rsp_allowin),
        .rsp_paddr   (rsp_paddr  ),
        .rsp_ex      (rsp_ex     )
    );

    function automatic void load_tables();
        // vpn2, asid, g, pfn0, v0, d0, pfn1, v1, d1
        entries[0]  = '{19'h00001, 8'h01, 1'b0, 20'h10000, 1'b1, 1'b1, 20'h10001, 1'b1, 1'b1};
        entries[1]  = '{19'h00002, 8'h01, 1'b0, 20'h20000, 1'b1, 1'b0, 20'h20001, 1'b1, 1'b1};
        entries[2]  = '{19'h00003, 8'h05, 1'b1, 20'h30000, 1'b1, 1'b1, 20'h30001, 1'b0, 1'b0};
        entries[3]  = '{19'h00004, 8'h02, 1'b0, 20'h40000, 1'b1, 1'b1, 20'h40001, 1'b1, 1'b1};
        entries[4]  = '{19'h40000, 8'h01, 1'b0, 20'h50000, 1'b1, 1'b1, 20'h50001, 1'b1, 1'b1};
        entries[5]  = '{19'h60000, 8'h01, 1'b0, 20'h70000, 1'b1, 1'b1, 20'h70001, 1'b1, 1'b1};
        entries[6]  = '{19'h00005, 8'h03, 1'b0, 20'h60000, 1'b0, 1'b0, 20'h60001, 1'b0, 1'b1};
        // shadowed by entry 0
        entries[7]  = '{19'h00001, 8'h01, 1'b0, 20'haaaaa, 1'b1, 1'b1, 20'haaaab, 1'b1, 1'b1};
        for (int i = 8; i < NUM_ENTRIES; i++) begin
            entries[i] = '{19'h00100 + 19'(i), 8'h10, 1'b0, 20'h80000 + 20'(i), 1'b1, 1'b1,
                           20'h81000 + 20'(i), 1'b1, 1'b1};
        end
        rewrite_row = '{19'h00004, 8'h02, 1'b0, 20'h4a000, 1'b0, 1'b0, 20'h4a001, 1'b1, 1'b0};
        // vaddr, asid, store, expected paddr, expected ex
        lookups[0]  = '{32'h0000_2abc, 8'h01, 1'b0, 32'h1000_0abc, XLATE_OK};
        lookups[1]  = '{32'h0000_3123, 8'h01, 1'b1, 32'h1000_1123, XLATE_OK};
        lookups[2]  = '{32'h0000_5ffc, 8'h01, 1'b1, 32'h2000_1ffc, XLATE_OK};
        lookups[3]  = '{32'h0000_6010, 8'h7f, 1'b0, 32'h3000_0010, XLATE_OK};
        lookups[4]  = '{32'hc000_0044, 8'h01, 1'b0, 32'h7000_0044, XLATE_OK};
        lookups[5]  = '{32'hc000_1800, 8'h01, 1'b1, 32'h7000_1800, XLATE_OK};
        lookups[6]  = '{32'h0000_2abc, 8'h02, 1'b0, 32'h0000_0000, XLATE_REFILL};
        lookups[7]  = '{32'h0010_0000, 8'h01, 1'b0, 32'h0000_0000, XLATE_REFILL};
        lookups[8]  = '{32'h0000_7000, 8'h01, 1'b0, 32'h0000_0000, XLATE_INVALID};
        lookups[9]  = '{32'h0000_a000, 8'h03, 1'b0, 32'h0000_0000, XLATE_INVALID};
        lookups[10] = '{32'h0000_b004, 8'h03, 1'b1, 32'h0000_0000, XLATE_INVALID};
        lookups[11] = '{32'h0000_4100, 8'h01, 1'b1, 32'h0000_0000, XLATE_MODIFIED};
        lookups[12] = '{32'h0000_4100, 8'h01, 1'b0, 32'h2000_0100, XLATE_OK};
        lookups[13] = '{32'h8000_1234, 8'h01, 1'b0, 32'h0000_1234, XLATE_OK};
        lookups[14] = '{32'ha123_4567, 8'h00, 1'b1, 32'h0123_4567, XLATE_OK};
        lookups[15] = '{32'h9fff_fffc, 8'h00, 1'b0, 32'h1fff_fffc, XLATE_OK};
        lookups[16] = '{32'h0000_8008, 8'h02, 1'b0, 32'h4000_0008, XLATE_OK};
        lookups[17] = '{32'h0000_9ff0, 8'h02, 1'b1, 32'h4000_1ff0, XLATE_OK};
        lookups[18] = '{32'hc000_0000, 8'h02, 1'b0, 32'h0000_0000, XLATE_REFILL};
        lookups[19] = '{32'h7fff_e000, 8'h01, 1'b0, 32'h0000_0000, XLATE_REFILL};
        // after entry 3 is rewritten
        lookups[20] = '{32'h0000_8008, 8'h02, 1'b0, 32'h0000_0000, XLATE_INVALID};
        lookups[21] = '{32'h0000_9ff0, 8'h02, 1'b1, 32'h0000_0000, XLATE_MODIFIED};
        lookups[22] = '{32'h0000_9ff0, 8'h02, 1'b0, 32'h4a00_1ff0, XLATE_OK};
        lookups[23] = '{32'h0000_2abc, 8'h01, 1'b0, 32'h1000_0abc, XLATE_OK};
    endfunction

    task automatic stop_on_error(input string msg);
        $display("** Error at %0t ns: %s", $time, msg);
        $display("TESTBENCH FAILED");
        $fatal(1, "stopping at the first error");
    endtask

    // called at 1 ns after an edge, returns at the same point
    task automatic write_entry(input int idx, input entry_row_t row);
        tlb_we  = 1'b1;
        w_index = tlb_idx_t'(idx);
        w_vpn2  = row.vpn2;
        w_asid  = row.asid;
        w_g     = row.g;
        w_pfn0  = row.pfn0;
        w_v0    = row.v0;
        w_d0    = row.d0;
        w_pfn1  = row.pfn1;
        w_v1    = row.v1;
        w_d1    = row.d1;
        @(posedge aclk);
        #1;
        tlb_we = 1'b0;
    endtask

    task automatic issue_lookup(input int idx);
        expect_t exp;
        req_valid = 1'b1;
        req_vaddr = lookups[idx].vaddr;
        req_asid  = lookups[idx].asid;
        req_store = lookups[idx].store;
        @(negedge aclk);
        while (!req_allowin) @(negedge aclk);
        // taken at the coming edge
        exp.row         = idx;
        exp.accept_edge = edge_cnt + 1;
        exp.check_lat   = !bp_on;
        exp_q.push_back(exp);
        issued++;
        @(posedge aclk);
        #1;
        req_valid = 1'b0;
    endtask

    task automatic wait_drain();
        while (received != issued) @(posedge aclk);
        #1;
    endtask

    always @(posedge aclk) begin
        edge_cnt <= edge_cnt + 1;
    end

    initial begin : back_pressure
        logic stall;
        rsp_allowin = 1'b1;
        forever begin
            @(posedge aclk);
            // picked at the edge, bp_on only moves 1 ns after one
            stall = bp_on && (($urandom % 3) == 0);
            #1;
            rsp_allowin = !stall;
        end
    end

    always @(negedge aclk) begin : monitor
        expect_t     exp;
        lookup_row_t row;
        if (rst_n && rsp_valid && rsp_allowin) begin
            assert (received < exp_q.size())
                else stop_on_error("a response arrived with no request outstanding");
            exp = exp_q[received];
            row = lookups[exp.row];
            assert (rsp_paddr == row.paddr)
                else stop_on_error($sformatf("row %0d paddr %h, expected %h",
                                             exp.row, rsp_paddr, row.paddr));
            assert (rsp_ex == row.ex)
                else stop_on_error($sformatf("row %0d ex %s, expected %s",
                                             exp.row, rsp_ex.name(), row.ex.name()));
            if (exp.check_lat) begin
                assert (edge_cnt == exp.accept_edge + 2)
                    else stop_on_error($sformatf("row %0d shown at edge %0d, accepted at %0d",
                                                 exp.row, edge_cnt, exp.accept_edge));
            end
            received++;
        end
    end

    initial begin : watchdog
        repeat (WATCHDOG_CYCLES) @(posedge aclk);
        stop_on_error("watchdog expired before the test sequence finished");
    end

    initial begin : stimulus
        int gap;
        void'($urandom(SEED));
        issued    = 0;
        bp_on     = 1'b0;
        req_valid = 1'b0;
        req_vaddr = '0;
        req_asid  = '0;
        req_store = 1'b0;
        tlb_we    = 1'b0;
        w_index   = '0;
        w_vpn2    = '0;
        w_asid    = '0;
        w_g       = 1'b0;
        w_pfn0    = '0;
        w_v0      = 1'b0;
        w_d0      = 1'b0;
        w_pfn1    = '0;
        w_v1      = 1'b0;
        w_d1      = 1'b0;
        load_tables();
        wait (rst_n === 1'b1);
        @(posedge aclk);
        #1;
        for (int i = 0; i < NUM_ENTRIES; i++) begin
            write_entry(i, entries[i]);
        end
        // back to back with the response side always ready
        for (int i = 0; i < FIRST_LATE; i++) begin
            issue_lookup(i);
        end
        wait_drain();
        // same rows again under random stalls and idle gaps
        bp_on = 1'b1;
        for (int i = 0; i < FIRST_LATE; i++) begin
            issue_lookup(i);
            gap = $urandom % 3;
            repeat (gap) begin
                @(posedge aclk);
                #1;
            end
        end
        wait_drain();
        bp_on = 1'b0;
        write_entry(REWRITE_IDX, rewrite_row);
        for (int i = FIRST_LATE; i < NUM_LOOKUPS; i++) begin
            issue_lookup(i);
        end
        wait_drain();
        if (DUT.props.hold_fails == 0 && DUT.props.full_fails == 0
            && DUT.props.reset_fails == 0) begin
            $display("TESTBENCH PASSED");
            $finish;
        end else begin
            $display("a handshake property failed during the run");
            $display("TESTBENCH FAILED");
            $fatal(1, "run ended with errors");
        end
    end

endmodule

`default_nettype wire

//--- xlate_props.sv
`timescale 1ns/1ns
`default_nettype none

module xlate_props (
    input logic                 aclk,
    input logic                 rst_n,
    input logic                 req_allowin,
    input logic                 rsp_valid,
    input logic                 rsp_allowin,
    input xlate_pkg::vaddr_t    rsp_paddr,
    input xlate_pkg::xlate_ex_e rsp_ex
);

    // failure counts, one per property
    int hold_fails  = 0;
    int full_fails  = 0;
    int reset_fails = 0;

    // a stalled response keeps its data until taken
    hold_stable: assert property (@(posedge aclk) disable iff (!rst_n)
        rsp_valid && !rsp_allowin |=> rsp_valid && $stable(rsp_paddr) && $stable(rsp_ex))
    else begin
        hold_fails++;
        $error("stalled response changed before it was taken");
    end

    // request side only blocks when the whole pipe is full and stalled
    full_stall: assert property (@(posedge aclk) disable iff (!rst_n)
        !req_allowin |-> rsp_valid && !rsp_allowin)
    else begin
        full_fails++;
        $error("req_allowin low without a stalled response");
    end

    reset_quiet: assert property (@(posedge aclk) !rst_n |-> !rsp_valid)
    else begin
        reset_fails++;
        $error("rsp_valid high during reset");
    end

endmodule

`default_nettype wire

//--- tb_clock.sv
`timescale 1ns/1ns
`default_nettype none

module tb_clock (
    output logic aclk,
    output logic rst_n
);

    localparam int HALF_PERIOD  = 4;
    localparam int RESET_CYCLES = 3;

    initial begin
        aclk = 1'b0;
        forever #HALF_PERIOD aclk = ~aclk;
    end

    // release just after the last reset edge
    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge aclk);
        #1;
        rst_n = 1'b1;
    end

endmodule

`default_nettype wire

//--- xlate_top.sv
`timescale 1ns/1ns
`default_nettype none

module xlate_top (
    input  logic                 aclk,
    input  logic                 rst_n,
    // request side
    input  logic                 req_valid,
    input  xlate_pkg::vaddr_t    req_vaddr,
    input  xlate_pkg::asid_t     req_asid,
    input  logic                 req_store,
    output logic                 req_allowin,
    // response side
    output logic                 rsp_valid,
    output xlate_pkg::vaddr_t    rsp_paddr,
    output xlate_pkg::xlate_ex_e rsp_ex,
    input  logic                 rsp_allowin,
    // tlb write port
    input  logic                 tlb_we,
    input  xlate_pkg::tlb_idx_t  w_index,
    input  xlate_pkg::vpn2_t     w_vpn2,
    input  xlate_pkg::asid_t     w_asid,
    input  logic                 w_g,
    input  xlate_pkg::pfn_t      w_pfn0,
    input  logic                 w_v0,
    input  logic                 w_d0,
    input  xlate_pkg::pfn_t      w_pfn1,
    input  logic                 w_v1,
    input  logic                 w_d1
);
    import xlate_pkg::*;

    xlate_req_t req_d;
    xlate_req_t req_q;
    xlate_hit_t hit_d;
    xlate_hit_t hit_q;
    xlate_rsp_t rsp_d;
    xlate_rsp_t rsp_q;

    logic req_valid_q;
    logic hit_valid_q;
    logic hit_allowin;
    logic rsp_stage_allowin;

    assign req_d.vaddr    = req_vaddr;
    assign req_d.asid     = req_asid;
    assign req_d.is_store = req_store;

    pipe_reg #(.payload_t(xlate_req_t)) req_stage (
        .aclk         (aclk        ),
        .rst_n        (rst_n       ),
        .in_valid     (req_valid   ),
        .in_payload   (req_d       ),
        .allowin      (req_allowin ),
        .next_allowin (hit_allowin ),
        .out_valid    (req_valid_q ),
        .out_payload  (req_q       )
    );

    // search driven straight from the request register
    tlb_array tlb (
        .aclk       (aclk                   ),
        .rst_n      (rst_n                  ),
        .s_vpn2     (req_q.vaddr[31:13]     ),
        .s_odd_page (req_q.vaddr[12]        ),
        .s_asid     (req_q.asid             ),
        .s_found    (hit_d.found            ),
        .s_pfn      (hit_d.pfn              ),
        .s_v        (hit_d.v                ),
        .s_d        (hit_d.d                ),
        .tlb_we     (tlb_we                 ),
        .w_index    (w_index                ),
        .w_vpn2     (w_vpn2                 ),
        .w_asid     (w_asid                 ),
        .w_g        (w_g                    ),
        .w_pfn0     (w_pfn0                 ),
        .w_v0       (w_v0                   ),
        .w_d0       (w_d0                   ),
        .w_pfn1     (w_pfn1                 ),
        .w_v1       (w_v1                   ),
        .w_d1       (w_d1                   )
    );

    assign hit_d.vaddr    = req_q.vaddr;
    assign hit_d.is_store = req_q.is_store;

    pipe_reg #(.payload_t(xlate_hit_t)) hit_stage (
        .aclk         (aclk             ),
        .rst_n        (rst_n            ),
        .in_valid     (req_valid_q      ),
        .in_payload   (hit_d            ),
        .allowin      (hit_allowin      ),
        .next_allowin (rsp_stage_allowin),
        .out_valid    (hit_valid_q      ),
        .out_payload  (hit_q            )
    );

    xlate_resolve_stage resolve (
        .hit (hit_q),
        .rsp (rsp_d)
    );

    pipe_reg #(.payload_t(xlate_rsp_t)) rsp_stage (
        .aclk         (aclk             ),
        .rst_n        (rst_n            ),
        .in_valid     (hit_valid_q      ),
        .in_payload   (rsp_d            ),
        .allowin      (rsp_stage_allowin),
        .next_allowin (rsp_allowin      ),
        .out_valid    (rsp_valid        ),
        .out_payload  (rsp_q            )
    );

    assign rsp_paddr = rsp_q.paddr;
    assign rsp_ex    = rsp_q.ex;

endmodule

`default_nettype wire

//--- xlate_resolve_stage.sv
`timescale 1ns/1ns
`default_nettype none

`include "xlate_settings.svh"

module xlate_resolve_stage (
    input  xlate_pkg::xlate_hit_t hit,
    output xlate_pkg::xlate_rsp_t rsp
);
    import xlate_pkg::*;

    logic unmapped;

    // kseg0 and kseg1 both start with 2'b10
    assign unmapped = (hit.vaddr[`XLATE_VADDR_W-1 -: 2] == 2'b10);

    always_comb begin
        rsp.paddr = '0;
        rsp.ex    = XLATE_OK;
        if (unmapped) begin
            // drop the segment bits, tlb result not used
            rsp.paddr = {3'b000, hit.vaddr[`XLATE_VADDR_W-4:0]};
        end else if (!hit.found) begin
            rsp.ex = XLATE_REFILL;
        end else if (!hit.v) begin
            rsp.ex = XLATE_INVALID;
        end else if (hit.is_store && !hit.d) begin
            // clean page written
            rsp.ex = XLATE_MODIFIED;
        end else begin
            rsp.paddr = {hit.pfn, hit.vaddr[`XLATE_PAGE_W-1:0]};
        end
    end

endmodule

`default_nettype wire

//--- tlb_array.sv
`timescale 1ns/1ns
`default_nettype none

`include "xlate_settings.svh"

module tlb_array (
    input  logic                aclk,
    input  logic                rst_n,
    // search port
    input  xlate_pkg::vpn2_t    s_vpn2,
    input  logic                s_odd_page,
    input  xlate_pkg::asid_t    s_asid,
    output logic                s_found,
    output xlate_pkg::pfn_t     s_pfn,
    output logic                s_v,
    output logic                s_d,
    // write port
    input  logic                tlb_we,
    input  xlate_pkg::tlb_idx_t w_index,
    input  xlate_pkg::vpn2_t    w_vpn2,
    input  xlate_pkg::asid_t    w_asid,
    input  logic                w_g,
    input  xlate_pkg::pfn_t     w_pfn0,
    input  logic                w_v0,
    input  logic                w_d0,
    input  xlate_pkg::pfn_t     w_pfn1,
    input  logic                w_v1,
    input  logic                w_d1
);
    import xlate_pkg::*;

    // entry fields, one array per field
    vpn2_t e_vpn2 [`XLATE_TLB_ENTRIES];
    asid_t e_asid [`XLATE_TLB_ENTRIES];
    logic  e_g    [`XLATE_TLB_ENTRIES];
    pfn_t  e_pfn0 [`XLATE_TLB_ENTRIES];
    logic  e_v0   [`XLATE_TLB_ENTRIES];
    logic  e_d0   [`XLATE_TLB_ENTRIES];
    pfn_t  e_pfn1 [`XLATE_TLB_ENTRIES];
    logic  e_v1   [`XLATE_TLB_ENTRIES];
    logic  e_d1   [`XLATE_TLB_ENTRIES];

    logic [`XLATE_TLB_ENTRIES-1:0] match;
    tlb_idx_t                      hit_idx;

    // write port, a search in the same cycle still sees the old entry
    always_ff @(posedge aclk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < `XLATE_TLB_ENTRIES; i++) begin
                e_vpn2[i] <= '0;
                e_asid[i] <= '0;
                e_g[i]    <= 1'b0;
                e_pfn0[i] <= '0;
                e_v0[i]   <= 1'b0;
                e_d0[i]   <= 1'b0;
                e_pfn1[i] <= '0;
                e_v1[i]   <= 1'b0;
                e_d1[i]   <= 1'b0;
            end
        end else if (tlb_we) begin
            e_vpn2[w_index] <= w_vpn2;
            e_asid[w_index] <= w_asid;
            e_g[w_index]    <= w_g;
            e_pfn0[w_index] <= w_pfn0;
            e_v0[w_index]   <= w_v0;
            e_d0[w_index]   <= w_d0;
            e_pfn1[w_index] <= w_pfn1;
            e_v1[w_index]   <= w_v1;
            e_d1[w_index]   <= w_d1;
        end
    end

    // global entries ignore the asid
    always_comb begin
        for (int i = 0; i < `XLATE_TLB_ENTRIES; i++) begin
            match[i] = (e_vpn2[i] == s_vpn2) && (e_g[i] || (e_asid[i] == s_asid));
        end
    end

    // scan downwards so the lowest matching index is the one kept
    always_comb begin
        s_found = 1'b0;
        hit_idx = '0;
        for (int i = `XLATE_TLB_ENTRIES - 1; i >= 0; i--) begin
            if (match[i]) begin
                s_found = 1'b1;
                hit_idx = tlb_idx_t'(i);
            end
        end
    end

    // even/odd page select
    assign s_pfn = s_odd_page ? e_pfn1[hit_idx] : e_pfn0[hit_idx];
    assign s_v   = s_odd_page ? e_v1[hit_idx]   : e_v0[hit_idx];
    assign s_d   = s_odd_page ? e_d1[hit_idx]   : e_d0[hit_idx];

endmodule

`default_nettype wire

//--- pipe_reg.sv
`timescale 1ns/1ns
`default_nettype none

module pipe_reg #(
    parameter type payload_t = logic
) (
    input  logic     aclk,
    input  logic     rst_n,
    // upstream side
    input  logic     in_valid,
    input  payload_t in_payload,
    output logic     allowin,
    // downstream side
    input  logic     next_allowin,
    output logic     out_valid,
    output payload_t out_payload
);

    logic     valid_q;
    payload_t payload_q;

    // take new data when empty or when the held item moves on this edge
    assign allowin = !valid_q || next_allowin;

    always_ff @(posedge aclk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q <= 1'b0;
        end else if (allowin) begin
            valid_q <= in_valid;
        end
    end

    // payload only follows a real transfer
    always_ff @(posedge aclk) begin
        if (allowin && in_valid) begin
            payload_q <= in_payload;
        end
    end

    assign out_valid   = valid_q;
    assign out_payload = payload_q;

endmodule

`default_nettype wire

//--- xlate_pkg.sv
`default_nettype none

`include "xlate_settings.svh"

package xlate_pkg;

    // virtual and physical addresses share one type
    typedef logic [`XLATE_VADDR_W-1:0] vaddr_t;
    typedef logic [`XLATE_ASID_W-1:0] asid_t;
    typedef logic [`XLATE_VPN2_W-1:0] vpn2_t;
    typedef logic [`XLATE_PFN_W-1:0] pfn_t;
    typedef logic [$clog2(`XLATE_TLB_ENTRIES)-1:0] tlb_idx_t;

    // translation result code
    typedef enum logic [1:0] {
        XLATE_OK       = 2'd0,
        XLATE_REFILL   = 2'd1,
        XLATE_INVALID  = 2'd2,
        XLATE_MODIFIED = 2'd3
    } xlate_ex_e;

    // request register payload
    typedef struct packed {
        vaddr_t vaddr;
        asid_t  asid;
        logic   is_store;
    } xlate_req_t;

    // hit register payload, page fields already picked by vaddr[12]
    typedef struct packed {
        vaddr_t vaddr;
        logic   is_store;
        logic   found;
        pfn_t   pfn;
        logic   v;
        logic   d;
    } xlate_hit_t;

    // response register payload
    typedef struct packed {
        vaddr_t    paddr;
        xlate_ex_e ex;
    } xlate_rsp_t;

endpackage

`default_nettype wire

//--- xlate_settings.svh
`ifndef XLATE_SETTINGS_SVH
`define XLATE_SETTINGS_SVH

// tlb depth
`define XLATE_TLB_ENTRIES 16

// address and field widths
`define XLATE_VADDR_W 32
`define XLATE_ASID_W 8

// vpn2 covers address bits 31..13, one entry maps an even/odd page pair
`define XLATE_VPN2_W 19
`define XLATE_PFN_W 20

// 4 KB pages
`define XLATE_PAGE_W 12

`endif
